//--- sd_spi_init.f
src/sd_spi_pkg.sv
src/sd_cmd_if.sv
src/sclk_gen.sv
src/crc7_serial.sv
src/cmd_shifter.sv
src/rsp_receiver.sv
src/sd_init_ctrl.sv
src/sd_spi_init_top.sv
verification/sd_card_model.sv
verification/sd_spi_init_checker.sv
verification/sd_spi_init_tb.sv

//--- verification/sd_spi_init_tb.sv
`timescale 1ns/100ps

module sd_spi_init_tb;

   localparam int POWERUP_CYCLES = 50;
   localparam int DONE_TIMEOUT   = 20000;

   logic        clk;
   logic        rst;
   logic        miso;
   logic        sclk;
   logic        mosi;
   logic        cs_n;
   logic        init_done;
   logic        card_hc;
   logic        card_v1;
   logic [1:0]  mode;
   logic [1:0]  busy_n;
   logic [2:0]  delay;
   logic [47:0] card_frame;
   logic [7:0]  card_frame_cnt;
   logic [7:0]  seen_cnt;

   logic [31:0] lfsr;
   int          checks;
   int          errors;
   logic        timed_out;
   logic [47:0] frames[$];
   logic [5:0]  exp_idx[$];
   logic [31:0] exp_arg[$];

   // Power-up and dummy clock monitor state
   int   pwr_cycles;
   int   dummy_rises;
   logic sclk_started;
   logic prev_sclk;
   logic prev_cs_n;

   sd_spi_init_top #(
      .POWERUP_CYCLES (POWERUP_CYCLES),
      .SCLK_DIV       (2),
      .RSP_TIMEOUT    (400)
   ) DUT (
      .clk         (clk),
      .rst         (rst),
      .miso_i      (miso),
      .sclk_o      (sclk),
      .mosi_o      (mosi),
      .cs_n_o      (cs_n),
      .init_done_o (init_done),
      .card_hc_o   (card_hc),
      .card_v1_o   (card_v1)
   );

   sd_card_model card (
      .rst         (rst),
      .sclk_i      (sclk),
      .mosi_i      (mosi),
      .cs_n_i      (cs_n),
      .mode_i      (mode),
      .busy_i      (busy_n),
      .delay_i     (delay),
      .miso_o      (miso),
      .frame_o     (card_frame),
      .frame_cnt_o (card_frame_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Galois LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      int          i;
      val = '0;
      for (i = 0; i < n; i++) begin
         val  = {val[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return val;
   endfunction

   // CRC7 over the frame body with the MSB first
   function automatic logic [6:0] crc7_ref(input logic [39:0] body);
      logic [6:0] crc;
      int         i;
      crc = '0;
      for (i = 39; i >= 0; i--) begin
         if (body[i] ^ crc[6]) begin
            crc = {crc[5:0], 1'b0} ^ 7'h09;
         end else begin
            crc = {crc[5:0], 1'b0};
         end
      end
      return crc;
   endfunction

   task automatic check_value(input string sig, input logic [47:0] got, input logic [47:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("MISMATCH at %0t: %s got %0h expected %0h", $time, sig, got, exp);
      end
   endtask

   task automatic expect_cmd(input logic [5:0] idx, input logic [31:0] arg);
      exp_idx.push_back(idx);
      exp_arg.push_back(arg);
   endtask

   // Log each decoded frame and pick the card's latency for the next one
   always @(posedge clk) begin
      if (rst) begin
         seen_cnt <= '0;
      end else if (card_frame_cnt != seen_cnt) begin
         seen_cnt <= card_frame_cnt;
         frames.push_back(card_frame);
         delay <= 3'(rand_bits(3));
      end
   end

   always @(posedge clk) begin
      if (rst) begin
         pwr_cycles   = 0;
         dummy_rises  = 0;
         sclk_started = 1'b0;
         prev_sclk    = 1'b1;
         prev_cs_n    = 1'b1;
      end else begin
         if (!sclk_started && sclk) begin
            pwr_cycles++;
         end else if (!sclk_started) begin
            sclk_started = 1'b1;
            assert (pwr_cycles >= POWERUP_CYCLES) else begin
               errors++;
               $display("ERROR at %0t: sclk_o started after %0d cycles", $time, pwr_cycles);
            end
         end
         // A rise counts as a dummy clock when chip select was high just before it
         if (sclk && !prev_sclk && prev_cs_n) begin
            dummy_rises++;
         end
         if (prev_cs_n && !cs_n) begin
            assert (dummy_rises >= 74) else begin
               errors++;
               $display("ERROR at %0t: cs_n_o fell after only %0d rises", $time, dummy_rises);
            end
         end
         prev_sclk = sclk;
         prev_cs_n = cs_n;
      end
   end

   task automatic apply_reset(input logic [1:0] m, input logic [1:0] b);
      @(posedge clk);
      mode   <= m;
      busy_n <= b;
      rst    <= 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   endtask

   task automatic wait_done();
      int cyc;
      cyc = 0;
      while (!init_done && cyc < DONE_TIMEOUT) begin
         @(posedge clk);
         cyc++;
      end
      assert (init_done) else begin
         errors++;
         timed_out = 1'b1;
         $display("ERROR at %0t: init_done_o not seen within %0d cycles", $time, DONE_TIMEOUT);
      end
   endtask

   task automatic compare_frames();
      logic [47:0] f;
      int          i;
      check_value("frame count", frames.size(), exp_idx.size());
      for (i = 0; i < frames.size() && i < exp_idx.size(); i++) begin
         f = frames[i];
         check_value($sformatf("frame %0d start", i), f[47:46], 2'b01);
         check_value($sformatf("frame %0d index", i), f[45:40], exp_idx[i]);
         check_value($sformatf("frame %0d argument", i), f[39:8], exp_arg[i]);
         check_value($sformatf("frame %0d crc7", i), f[7:1], crc7_ref(f[47:8]));
         check_value($sformatf("frame %0d stop", i), f[0], 1'b1);
      end
   endtask

   task automatic run_scenario(input logic [1:0] m);
      logic [1:0] n;
      int         i;
      n = 2'(rand_bits(2));
      $display("Scenario %0d with %0d busy answers", m, n);
      apply_reset(m, n);
      frames.delete();
      exp_idx.delete();
      exp_arg.delete();
      expect_cmd(6'd0, 32'h0);
      expect_cmd(6'd8, 32'h1AA);
      if (m == 2'd3) begin
         expect_cmd(6'd41, 32'h0);
         for (i = 0; i <= n; i++) begin
            expect_cmd(6'd1, 32'h0);
         end
         expect_cmd(6'd16, 32'h200);
      end else begin
         for (i = 0; i <= n; i++) begin
            expect_cmd(6'd41, (m == 2'd2) ? 32'h0 : 32'h4000_0000);
         end
         if (m != 2'd2) begin
            expect_cmd(6'd58, 32'h0);
         end
         if (m != 2'd0) begin
            expect_cmd(6'd16, 32'h200);
         end
      end
      wait_done();
      if (!timed_out) begin
         compare_frames();
         check_value("card_hc_o", card_hc, m == 2'd0);
         check_value("card_v1_o", card_v1, m >= 2'd2);
         // Chip select stays low once the command sequence has begun
         check_value("cs_n_o", cs_n, 1'b0);
      end
   endtask

   initial begin
      lfsr      = 32'h5874de63;
      checks    = 0;
      errors    = 0;
      timed_out = 1'b0;
      rst       = 1'b1;
      mode      = 2'd0;
      busy_n    = 2'd0;
      delay     = 3'd0;
      run_scenario(2'd0);
      if (!timed_out) run_scenario(2'd1);
      if (!timed_out) run_scenario(2'd2);
      if (!timed_out) run_scenario(2'd3);
      $display("Checks %0d, errors %0d, assertion failures %0d",
               checks, errors, DUT.u_checker.fail_cnt);
      if (errors == 0 && DUT.u_checker.fail_cnt == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- verification/sd_spi_init_checker.sv
`timescale 1ns/100ps

module sd_spi_init_checker (
   input logic clk,
   input logic rst,
   input logic sclk_i,
   input logic mosi_i,
   input logic cs_n_i,
   input logic init_done_i
);

   int   fail_cnt = 0;
   logic sclk_started;

   // Set by the first low level of sclk after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         sclk_started <= 1'b0;
      end else if (!sclk_i) begin
         sclk_started <= 1'b1;
      end
   end

   done_sticky: assert property (@(posedge clk) disable iff (rst) !$fell(init_done_i))
      else begin
         $error("init_done_o fell without a reset");
         fail_cnt++;
      end

   cs_before_sclk: assert property (@(posedge clk) disable iff (rst) !sclk_started |-> cs_n_i)
      else begin
         $error("cs_n_o low before sclk started");
         fail_cnt++;
      end

   mosi_idle: assert property (@(posedge clk) disable iff (rst) cs_n_i |-> mosi_i)
      else begin
         $error("mosi_o low while cs_n_o high");
         fail_cnt++;
      end

endmodule

bind sd_spi_init_top sd_spi_init_checker u_checker (
   .clk         (clk),
   .rst         (rst),
   .sclk_i      (sclk_o),
   .mosi_i      (mosi_o),
   .cs_n_i      (cs_n_o),
   .init_done_i (init_done_o)
);

//--- verification/sd_card_model.sv
`timescale 1ns/100ps

module sd_card_model (
   input  logic        rst,
   input  logic        sclk_i,
   input  logic        mosi_i,
   input  logic        cs_n_i,
   input  logic [1:0]  mode_i,
   input  logic [1:0]  busy_i,
   input  logic [2:0]  delay_i,
   output logic        miso_o,
   output logic [47:0] frame_o,
   output logic [7:0]  frame_cnt_o
);

   // Mode 0 is a v2 high capacity card, 1 v2 standard capacity, 2 v1, 3 rejects ACMD41
   logic        tx_q[$];
   logic [47:0] rx_sr;
   int          rx_cnt;
   int          busy_given;

   initial begin
      miso_o      = 1'b1;
      frame_cnt_o = '0;
      rx_cnt      = 0;
      busy_given  = 0;
   end

   // Leading 0xFF bytes model the card's response latency
   task automatic queue_rsp(input logic [39:0] rsp, input int nbits);
      int i;
      for (i = 0; i < 8 * delay_i; i++) begin
         tx_q.push_back(1'b1);
      end
      for (i = nbits - 1; i >= 0; i--) begin
         tx_q.push_back(rsp[i]);
      end
   endtask

   task automatic send_busy();
      if (busy_given < busy_i) begin
         busy_given++;
         queue_rsp(40'h01, 8);
      end else begin
         queue_rsp(40'h00, 8);
      end
   endtask

   task automatic answer(input logic [47:0] f);
      case (f[45:40])
         6'd0:  queue_rsp(40'h01, 8);
         6'd8: begin
            // v1 cards stay silent on CMD8
            if (mode_i < 2'd2) begin
               queue_rsp({8'h00, 20'h0, f[19:8]}, 40);
            end
         end
         6'd41: begin
            if (mode_i == 2'd3) begin
               queue_rsp(40'h05, 8);
            end else begin
               send_busy();
            end
         end
         6'd1:  send_busy();
         6'd58: queue_rsp((mode_i == 2'd0) ? 40'h00_C0FF_8000 : 40'h00_80FF_8000, 40);
         6'd16: queue_rsp(40'h00, 8);
         default: queue_rsp(40'h04, 8);
      endcase
   endtask

   always @(negedge sclk_i or posedge rst) begin
      if (rst) begin
         tx_q.delete();
         rx_cnt      = 0;
         busy_given  = 0;
         miso_o      <= 1'b1;
         frame_cnt_o <= '0;
      end else begin
         if (tx_q.size() > 0) begin
            miso_o <= tx_q.pop_front();
         end else begin
            miso_o <= 1'b1;
         end
         // Idle MOSI is high so the first 0 is the start bit
         if (!cs_n_i && (rx_cnt > 0 || !mosi_i)) begin
            rx_sr  = {rx_sr[46:0], mosi_i};
            rx_cnt = rx_cnt + 1;
            if (rx_cnt == 48) begin
               rx_cnt      = 0;
               frame_o     <= rx_sr;
               frame_cnt_o <= frame_cnt_o + 1'b1;
               answer(rx_sr);
            end
         end
      end
   end

endmodule

//--- src/sd_spi_init_top.sv
`timescale 1ns/100ps

module sd_spi_init_top #(
   parameter int POWERUP_CYCLES = 1000,
   parameter int SCLK_DIV       = 2,
   parameter int RSP_TIMEOUT    = 400
) (
   input  logic clk,
   input  logic rst,
   input  logic miso_i,
   output logic sclk_o,
   output logic mosi_o,
   output logic cs_n_o,
   output logic init_done_o,
   output logic card_hc_o,
   output logic card_v1_o
);

   logic sclk_en;
   logic sclk_rise;

   sd_cmd_if bus ();

   sclk_gen #(
      .SCLK_DIV (SCLK_DIV)
   ) u_sclk_gen (
      .clk         (clk),
      .rst         (rst),
      .sclk_en_i   (sclk_en),
      .sclk_o      (sclk_o),
      .sclk_rise_o (sclk_rise),
      .sclk_fall_o ()
   );

   cmd_shifter u_cmd_shifter (
      .clk         (clk),
      .rst         (rst),
      .sclk_rise_i (sclk_rise),
      .bus         (bus.shift),
      .mosi_o      (mosi_o)
   );

   rsp_receiver #(
      .RSP_TIMEOUT (RSP_TIMEOUT)
   ) u_rsp_receiver (
      .clk         (clk),
      .rst         (rst),
      .miso_i      (miso_i),
      .sclk_rise_i (sclk_rise),
      .bus         (bus.recv)
   );

   sd_init_ctrl #(
      .POWERUP_CYCLES (POWERUP_CYCLES)
   ) u_sd_init_ctrl (
      .clk         (clk),
      .rst         (rst),
      .sclk_rise_i (sclk_rise),
      .bus         (bus.ctrl),
      .sclk_en_o   (sclk_en),
      .cs_n_o      (cs_n_o),
      .init_done_o (init_done_o),
      .card_hc_o   (card_hc_o),
      .card_v1_o   (card_v1_o)
   );

endmodule

//--- src/sd_init_ctrl.sv
`timescale 1ns/100ps

module sd_init_ctrl #(
   parameter int POWERUP_CYCLES = 1000
) (
   input  logic   clk,
   input  logic   rst,
   input  logic   sclk_rise_i,
   sd_cmd_if.ctrl bus,
   output logic   sclk_en_o,
   output logic   cs_n_o,
   output logic   init_done_o,
   output logic   card_hc_o,
   output logic   card_v1_o
);

   localparam int PWR_W = $clog2(POWERUP_CYCLES + 1);

   // Steps inside every command state
   typedef enum logic [1:0] {
      PH_ISSUE,
      PH_SEND,
      PH_WAIT
   } phase_e;

   sd_spi_pkg::init_state_e state;
   phase_e                  phase;
   logic [PWR_W-1:0]        pwr_cnt;
   logic [6:0]              dummy_cnt;
   sd_spi_pkg::cmd_index_t  cmd_idx;
   sd_spi_pkg::cmd_arg_t    cmd_arg;
   sd_spi_pkg::rsp_kind_e   cmd_rsp;
   logic                    rsp_end;
   logic                    r1_ready;
   logic                    r1_idle;

   assign rsp_end  = bus.rsp_done || bus.rsp_timeout;
   assign r1_ready = bus.rsp_done && (bus.r1 == 8'h00);
   assign r1_idle  = bus.rsp_done && (bus.r1 == 8'h01);

   // Command selection per state
   always_comb begin
      cmd_idx = sd_spi_pkg::CMD0_IDX;
      cmd_arg = '0;
      cmd_rsp = sd_spi_pkg::RSP_R1;
      case (state)
         sd_spi_pkg::ST_CMD8: begin
            cmd_idx = sd_spi_pkg::CMD8_IDX;
            cmd_arg = sd_spi_pkg::CMD8_ARG;
            cmd_rsp = sd_spi_pkg::RSP_R37;
         end
         sd_spi_pkg::ST_ACMD41: begin
            cmd_idx = sd_spi_pkg::ACMD41_IDX;
            cmd_arg = card_v1_o ? '0 : sd_spi_pkg::ACMD41_HCS_ARG;
         end
         sd_spi_pkg::ST_CMD58: begin
            cmd_idx = sd_spi_pkg::CMD58_IDX;
            cmd_rsp = sd_spi_pkg::RSP_R37;
         end
         sd_spi_pkg::ST_CMD1:  cmd_idx = sd_spi_pkg::CMD1_IDX;
         sd_spi_pkg::ST_CMD16: begin
            cmd_idx = sd_spi_pkg::CMD16_IDX;
            cmd_arg = sd_spi_pkg::CMD16_ARG;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state         <= sd_spi_pkg::ST_POWERUP;
         phase         <= PH_ISSUE;
         pwr_cnt       <= '0;
         dummy_cnt     <= '0;
         sclk_en_o     <= 1'b0;
         cs_n_o        <= 1'b1;
         init_done_o   <= 1'b0;
         card_hc_o     <= 1'b0;
         card_v1_o     <= 1'b0;
         bus.cmd_start <= 1'b0;
         bus.rsp_start <= 1'b0;
      end else begin
         bus.cmd_start <= 1'b0;
         bus.rsp_start <= 1'b0;
         case (state)
            sd_spi_pkg::ST_POWERUP: begin
               if (pwr_cnt == PWR_W'(POWERUP_CYCLES - 1)) begin
                  sclk_en_o <= 1'b1;
                  state     <= sd_spi_pkg::ST_DUMMY_CLK;
               end else begin
                  pwr_cnt <= pwr_cnt + 1'b1;
               end
            end
            sd_spi_pkg::ST_DUMMY_CLK: begin
               // Chip select drops once the last dummy rise is seen
               if (sclk_rise_i) begin
                  if (dummy_cnt == 7'(sd_spi_pkg::DUMMY_CLKS - 1)) begin
                     cs_n_o <= 1'b0;
                     state  <= sd_spi_pkg::ST_CMD0;
                  end else begin
                     dummy_cnt <= dummy_cnt + 1'b1;
                  end
               end
            end
            sd_spi_pkg::ST_DONE: ;
            default: begin
               case (phase)
                  PH_ISSUE: begin
                     bus.cmd_start <= 1'b1;
                     phase         <= PH_SEND;
                  end
                  PH_SEND: begin
                     if (bus.cmd_done) begin
                        bus.rsp_start <= 1'b1;
                        phase         <= PH_WAIT;
                     end
                  end
                  default: begin
                     if (rsp_end) begin
                        // Staying in the same state reissues the command
                        phase <= PH_ISSUE;
                        case (state)
                           sd_spi_pkg::ST_CMD0: begin
                              if (r1_idle) state <= sd_spi_pkg::ST_CMD8;
                           end
                           sd_spi_pkg::ST_CMD8: begin
                              if (bus.rsp_timeout || bus.r1 != 8'h00) card_v1_o <= 1'b1;
                              state <= sd_spi_pkg::ST_ACMD41;
                           end
                           sd_spi_pkg::ST_ACMD41: begin
                              if (r1_ready) begin
                                 state <= card_v1_o ? sd_spi_pkg::ST_CMD16
                                                    : sd_spi_pkg::ST_CMD58;
                              end else if (card_v1_o && !r1_idle) begin
                                 // Timeout or error on a v1 card, fall back to MMC init
                                 state <= sd_spi_pkg::ST_CMD1;
                              end
                           end
                           sd_spi_pkg::ST_CMD1: begin
                              if (r1_ready) state <= sd_spi_pkg::ST_CMD16;
                           end
                           sd_spi_pkg::ST_CMD58: begin
                              if (bus.rsp_done) begin
                                 if (bus.r37[sd_spi_pkg::OCR_CCS_BIT]) begin
                                    card_hc_o   <= 1'b1;
                                    init_done_o <= 1'b1;
                                    state       <= sd_spi_pkg::ST_DONE;
                                 end else begin
                                    state <= sd_spi_pkg::ST_CMD16;
                                 end
                              end
                           end
                           sd_spi_pkg::ST_CMD16: begin
                              if (r1_ready) begin
                                 init_done_o <= 1'b1;
                                 state       <= sd_spi_pkg::ST_DONE;
                              end
                           end
                           default: ;
                        endcase
                     end
                  end
               endcase
            end
         endcase
      end
   end

   // Frame and response kind are set up together with cmd_start
   always_ff @(posedge clk) begin
      if (phase == PH_ISSUE) begin
         bus.cmd_frame <= {2'b01, cmd_idx, cmd_arg};
         bus.rsp_kind  <= cmd_rsp;
      end
   end

endmodule

//--- src/rsp_receiver.sv
`timescale 1ns/100ps

module rsp_receiver #(
   parameter int RSP_TIMEOUT = 400
) (
   input  logic   clk,
   input  logic   rst,
   input  logic   miso_i,
   input  logic   sclk_rise_i,
   sd_cmd_if.recv bus
);

   localparam int TO_W = $clog2(RSP_TIMEOUT + 1);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_HUNT,
      RX_SHIFT
   } rx_state_e;

   rx_state_e             state;
   sd_spi_pkg::rsp_kind_e kind;
   sd_spi_pkg::r37_t      rx_sr;
   sd_spi_pkg::r37_t      rx_next;
   logic [TO_W-1:0]       to_cnt;
   logic [5:0]            bit_cnt;
   logic [5:0]            last_bit;
   logic                  start_seen;
   logic                  last;

   assign rx_next    = {rx_sr[38:0], miso_i};
   assign last_bit   = (kind == sd_spi_pkg::RSP_R1) ? 6'd7 : 6'd39;
   // Start bit doubles as the MSB of the R1 byte
   assign start_seen = (state == RX_HUNT) && sclk_rise_i && !miso_i;
   assign last       = (state == RX_SHIFT) && sclk_rise_i && (bit_cnt == last_bit);

   always_ff @(posedge clk) begin
      if (rst) begin
         state           <= RX_IDLE;
         kind            <= sd_spi_pkg::RSP_R1;
         to_cnt          <= '0;
         bit_cnt         <= '0;
         bus.rsp_done    <= 1'b0;
         bus.rsp_timeout <= 1'b0;
      end else begin
         bus.rsp_done    <= 1'b0;
         bus.rsp_timeout <= 1'b0;
         if (bus.rsp_start) begin
            state  <= RX_HUNT;
            kind   <= bus.rsp_kind;
            to_cnt <= '0;
         end else begin
            case (state)
               RX_HUNT: begin
                  if (start_seen) begin
                     state   <= RX_SHIFT;
                     bit_cnt <= 6'd1;
                  end else if (to_cnt == TO_W'(RSP_TIMEOUT - 1)) begin
                     state           <= RX_IDLE;
                     bus.rsp_timeout <= 1'b1;
                  end else begin
                     to_cnt <= to_cnt + 1'b1;
                  end
               end
               RX_SHIFT: begin
                  if (sclk_rise_i) begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
                  if (last) begin
                     state        <= RX_IDLE;
                     bus.rsp_done <= 1'b1;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start_seen) begin
         rx_sr <= '0;
      end else if ((state == RX_SHIFT) && sclk_rise_i) begin
         rx_sr <= rx_next;
      end
   end

   // All ones reads as "no answer" until a response completes
   always_ff @(posedge clk) begin
      if (bus.rsp_start) begin
         bus.r1  <= '1;
         bus.r37 <= '1;
      end else if (last) begin
         bus.r1  <= (kind == sd_spi_pkg::RSP_R1) ? rx_next[7:0] : rx_next[39:32];
         bus.r37 <= rx_next;
      end
   end

endmodule

//--- src/cmd_shifter.sv
`timescale 1ns/100ps

module cmd_shifter (
   input  logic    clk,
   input  logic    rst,
   input  logic    sclk_rise_i,
   sd_cmd_if.shift bus,
   output logic    mosi_o
);

   sd_spi_pkg::cmd_frame_t frame_sr;
   sd_spi_pkg::crc7_t      crc;
   logic [5:0]             bit_cnt;
   logic [2:0]             crc_sel;
   logic                   busy;
   logic                   crc_en;

   // Body bits 0..39 go through the CRC as they leave
   assign crc_en = busy && sclk_rise_i && (bit_cnt < 6'd40);

   // Bits 40..46 carry crc[6] down to crc[0]
   assign crc_sel = 3'(6'd46 - bit_cnt);

   crc7_serial u_crc7 (
      .clk     (clk),
      .rst     (rst),
      .clear_i (bus.cmd_start),
      .en_i    (crc_en),
      .bit_i   (frame_sr[39]),
      .crc_o   (crc)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         busy         <= 1'b0;
         bit_cnt      <= '0;
         mosi_o       <= 1'b1;
         bus.cmd_done <= 1'b0;
      end else begin
         bus.cmd_done <= 1'b0;
         if (bus.cmd_start) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
         end else if (busy && sclk_rise_i) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt < 6'd40) begin
               mosi_o <= frame_sr[39];
            end else if (bit_cnt < 6'd47) begin
               mosi_o <= crc[crc_sel];
            end else begin
               // Stop bit, MOSI then idles high
               mosi_o       <= 1'b1;
               busy         <= 1'b0;
               bus.cmd_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bus.cmd_start) begin
         frame_sr <= bus.cmd_frame;
      end else if (crc_en) begin
         frame_sr <= {frame_sr[38:0], 1'b0};
      end
   end

endmodule

//--- src/crc7_serial.sv
`timescale 1ns/100ps

module crc7_serial (
   input  logic              clk,
   input  logic              rst,
   input  logic              clear_i,
   input  logic              en_i,
   input  logic              bit_i,
   output sd_spi_pkg::crc7_t crc_o
);

   logic fb;

   // Feedback of x^7 + x^3 + 1, MSB first
   assign fb = bit_i ^ crc_o[6];

   always_ff @(posedge clk) begin
      if (rst || clear_i) begin
         crc_o <= '0;
      end else if (en_i) begin
         crc_o <= {crc_o[5:3], crc_o[2] ^ fb, crc_o[1:0], fb};
      end
   end

endmodule

//--- src/sclk_gen.sv
`timescale 1ns/100ps

module sclk_gen #(
   parameter int SCLK_DIV = 2
) (
   input  logic clk,
   input  logic rst,
   input  logic sclk_en_i,
   output logic sclk_o,
   output logic sclk_rise_o,
   output logic sclk_fall_o
);

   localparam int CNT_W = $clog2(SCLK_DIV + 1);

   logic [CNT_W-1:0] div_cnt;
   logic             toggle;

   // Last clk cycle of the current half period
   assign toggle = sclk_en_i && (div_cnt == CNT_W'(SCLK_DIV - 1));

   // Strobes line up with the cycle in which the sclk register flips
   assign sclk_rise_o = toggle && !sclk_o;
   assign sclk_fall_o = toggle && sclk_o;

   always_ff @(posedge clk) begin
      if (rst || !sclk_en_i) begin
         // Idle level is high, so the first edge after enable is a fall
         div_cnt <= '0;
         sclk_o  <= 1'b1;
      end else if (toggle) begin
         div_cnt <= '0;
         sclk_o  <= ~sclk_o;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

endmodule

//--- src/sd_cmd_if.sv
`timescale 1ns/100ps

interface sd_cmd_if;

   // Command path
   sd_spi_pkg::cmd_frame_t cmd_frame;
   logic                   cmd_start;
   logic                   cmd_done;

   // Response path, r1 and r37 hold until the next rsp_start
   sd_spi_pkg::rsp_kind_e  rsp_kind;
   logic                   rsp_start;
   logic                   rsp_done;
   logic                   rsp_timeout;
   sd_spi_pkg::r1_t        r1;
   sd_spi_pkg::r37_t       r37;

   modport ctrl (
      output cmd_frame, cmd_start, rsp_kind, rsp_start,
      input  cmd_done, rsp_done, rsp_timeout, r1, r37
   );

   modport shift (
      input  cmd_frame, cmd_start,
      output cmd_done
   );

   modport recv (
      input  rsp_kind, rsp_start,
      output rsp_done, rsp_timeout, r1, r37
   );

endinterface

//--- src/sd_spi_pkg.sv
package sd_spi_pkg;

   // Widths that carry a meaning on the SPI command path
   typedef logic [5:0]  cmd_index_t;
   typedef logic [31:0] cmd_arg_t;
   // Start pattern 01, index and argument; CRC7 and stop bit are added serially
   typedef logic [39:0] cmd_frame_t;
   typedef logic [6:0]  crc7_t;
   typedef logic [7:0]  r1_t;
   // R1 part in [39:32], OCR or CMD8 echo in [31:0]
   typedef logic [39:0] r37_t;

   typedef enum logic {
      RSP_R1,
      RSP_R37
   } rsp_kind_e;

   typedef enum logic [3:0] {
      ST_POWERUP,
      ST_DUMMY_CLK,
      ST_CMD0,
      ST_CMD8,
      ST_ACMD41,
      ST_CMD58,
      ST_CMD1,
      ST_CMD16,
      ST_DONE
   } init_state_e;

   // Command indices used during start-up
   localparam cmd_index_t CMD0_IDX   = 6'd0;
   localparam cmd_index_t CMD1_IDX   = 6'd1;
   localparam cmd_index_t CMD8_IDX   = 6'd8;
   localparam cmd_index_t ACMD41_IDX = 6'd41;
   localparam cmd_index_t CMD16_IDX  = 6'd16;
   localparam cmd_index_t CMD58_IDX  = 6'd58;

   // 2.7-3.6 V range with check pattern 0xAA
   localparam cmd_arg_t CMD8_ARG       = 32'h0000_01AA;
   // Host supports high capacity
   localparam cmd_arg_t ACMD41_HCS_ARG = 32'h4000_0000;
   // 512 byte blocks for standard capacity cards
   localparam cmd_arg_t CMD16_ARG      = 32'h0000_0200;

   localparam int DUMMY_CLKS  = 74;
   localparam int OCR_CCS_BIT = 30;

endpackage
